// File: rtl/lsu_pkg.sv
package lsu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;

  // loads have bit 3 clear, stores have it set
  typedef enum logic [3:0]
  {
    LB  = 4'h0,
    LH  = 4'h1,
    LW  = 4'h2,
    LBU = 4'h4,
    LHU = 4'h5,
    SB  = 4'h8,
    SH  = 4'h9,
    SW  = 4'ha
  } mem_op_e;

  typedef logic [DATA_W-1:0] data_word_t;

  // one bus word seen as byte lanes or half lanes
  typedef union packed
  {
    logic [3:0][7:0]  b;
    logic [1:0][15:0] h;
  } lane_word_u;

endpackage

// File: rtl/cache_pkg.sv
package cache_pkg;

  // direct mapped with one word per line
  localparam int L1D_LINES = 16;
  localparam int IDX_W = 4;
  // tag is address bits 31..6
  localparam int TAG_W = 26;

  typedef logic [IDX_W-1:0] l1d_idx_t;
  typedef logic [TAG_W-1:0] l1d_tag_t;

  // cacheable regions with an exclusive upper bound
  localparam logic [31:0] CACHE_RANGE_0_LO = 32'h8000_0000;
  localparam logic [31:0] CACHE_RANGE_0_HI = 32'h8040_0000;
  localparam logic [31:0] CACHE_RANGE_1_LO = 32'ha000_0000;
  localparam logic [31:0] CACHE_RANGE_1_HI = 32'hc000_0000;

endpackage

// File: rtl/l1d_if.sv
`timescale 1ns/100ps

interface l1d_if
  import lsu_pkg::*;
();

  logic [ADDR_W-1:0] addr;
  logic              lookup;
  logic              hit;
  data_word_t        hit_data;
  logic              fill;
  data_word_t        fill_data;
  logic              inval;

  modport ctrl (
    output addr, lookup, fill, fill_data, inval,
    input  hit, hit_data
  );

  modport cache (
    input  addr, lookup, fill, fill_data, inval,
    output hit, hit_data
  );

endinterface

// File: rtl/lsu_ctrl.sv
`timescale 1ns/100ps

module lsu_ctrl
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              req_valid_i,
  input  mem_op_e           req_op_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  data_word_t        req_wdata_i,
  output logic              req_ready_o,
  output logic              ar_valid_o,
  output logic [ADDR_W-1:0] ar_addr_o,
  input  logic              r_valid_i,
  input  data_word_t        r_data_i,
  output logic              aw_valid_o,
  output logic [ADDR_W-1:0] aw_addr_o,
  output data_word_t        w_data_o,
  output logic [STRB_W-1:0] w_strb_o,
  input  logic              w_ready_i,
  output logic              raw_valid_o,
  output data_word_t        raw_data_o,
  output mem_op_e           op_o,
  output logic [1:0]        offset_o,
  output logic              store_done_o,
  l1d_if.ctrl               cache
);

  typedef enum logic [2:0]
  {
    ST_IDLE,
    ST_LOOKUP,
    ST_BUS_RD,
    ST_BUS_WR,
    ST_DONE
  } state_e;

  state_e            state_q;
  state_e            state_d;
  mem_op_e           op_q;
  logic [ADDR_W-1:0] addr_q;
  data_word_t        wdata_q;
  data_word_t        rdata_q;
  lane_word_u        wlanes;
  logic [STRB_W-1:0] strb_base;
  logic              accept;
  logic              req_is_store;
  logic              op_is_store;
  logic              lookup_hit;

  assign req_is_store = (req_op_i == SB) || (req_op_i == SH) || (req_op_i == SW);
  assign op_is_store  = (op_q == SB) || (op_q == SH) || (op_q == SW);

  assign lookup_hit = (state_q == ST_LOOKUP) && cache.hit;

  // ready again in the cycle that carries the result
  assign req_ready_o = (state_q == ST_IDLE) || (state_q == ST_DONE) || lookup_hit;
  assign accept      = req_valid_i && req_ready_o;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE, ST_DONE:
      begin
        if (accept)
          state_d = req_is_store ? ST_BUS_WR : ST_LOOKUP;
        else
          state_d = ST_IDLE;
      end
      ST_LOOKUP:
      begin
        if (cache.hit)
        begin
          if (accept)
            state_d = req_is_store ? ST_BUS_WR : ST_LOOKUP;
          else
            state_d = ST_IDLE;
        end
        else if (r_valid_i)
          state_d = ST_DONE;
        else
          state_d = ST_BUS_RD;
      end
      ST_BUS_RD:
      begin
        if (r_valid_i)
          state_d = ST_DONE;
      end
      ST_BUS_WR:
      begin
        if (w_ready_i)
          state_d = ST_DONE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      op_q    <= req_op_i;
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
    end
    if (ar_valid_o && r_valid_i)
      rdata_q <= r_data_i;
  end

  // read request goes out as soon as the lookup misses
  assign ar_valid_o = ((state_q == ST_LOOKUP) && !cache.hit) || (state_q == ST_BUS_RD);
  assign ar_addr_o  = {addr_q[ADDR_W-1:2], 2'b00};

  always_comb
  begin
    case (op_q)
      SB:      strb_base = 4'b0001;
      SH:      strb_base = 4'b0011;
      SW:      strb_base = 4'b1111;
      default: strb_base = 4'b0000;
    endcase
  end

  // replicate low lanes so the strobe picks the right copy
  assign wlanes = wdata_q;
  always_comb
  begin
    case (op_q)
      SB:      w_data_o = {4{wlanes.b[0]}};
      SH:      w_data_o = {2{wlanes.h[0]}};
      default: w_data_o = wdata_q;
    endcase
  end

  assign aw_valid_o = (state_q == ST_BUS_WR);
  assign aw_addr_o  = {addr_q[ADDR_W-1:2], 2'b00};
  assign w_strb_o   = aw_valid_o ? (strb_base << addr_q[1:0]) : '0;

  assign cache.addr      = addr_q;
  assign cache.lookup    = (state_q == ST_LOOKUP);
  assign cache.fill      = ar_valid_o && r_valid_i;
  assign cache.fill_data = r_data_i;
  // write-around drops the line when the store completes
  assign cache.inval     = aw_valid_o && w_ready_i;

  assign raw_valid_o  = lookup_hit || ((state_q == ST_DONE) && !op_is_store);
  assign raw_data_o   = (state_q == ST_LOOKUP) ? cache.hit_data : rdata_q;
  assign op_o         = op_q;
  assign offset_o     = addr_q[1:0];
  assign store_done_o = (state_q == ST_DONE) && op_is_store;

endmodule

// File: rtl/l1d_cache.sv
`timescale 1ns/100ps

module l1d_cache
  import lsu_pkg::*;
  import cache_pkg::*;
(
  input  logic clk,
  input  logic arst_n_i,
  l1d_if.cache l1d
);

  data_word_t           data_q [L1D_LINES];
  l1d_tag_t             tag_q  [L1D_LINES];
  logic [L1D_LINES-1:0] valid_q;
  l1d_idx_t             idx;
  l1d_tag_t             tag;
  logic                 tag_match;
  logic                 cacheable;

  // word offset below the index
  assign idx = l1d.addr[IDX_W+1:2];
  assign tag = l1d.addr[ADDR_W-1:IDX_W+2];

  assign tag_match = (tag_q[idx] == tag);

  assign cacheable =
    ((l1d.addr >= CACHE_RANGE_0_LO) && (l1d.addr < CACHE_RANGE_0_HI)) ||
    ((l1d.addr >= CACHE_RANGE_1_LO) && (l1d.addr < CACHE_RANGE_1_HI));

  assign l1d.hit      = l1d.lookup && valid_q[idx] && tag_match;
  assign l1d.hit_data = data_q[idx];

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      valid_q <= '0;
    else if (l1d.fill && cacheable)
      valid_q[idx] <= 1'b1;
    else if (l1d.inval && tag_match)
      valid_q[idx] <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (l1d.fill && cacheable)
    begin
      data_q[idx] <= l1d.fill_data;
      tag_q[idx]  <= tag;
    end
  end

endmodule

// File: rtl/load_align.sv
`timescale 1ns/100ps

module load_align
  import lsu_pkg::*;
(
  input  data_word_t raw_i,
  input  mem_op_e    op_i,
  input  logic [1:0] offset_i,
  output data_word_t data_o
);

  lane_word_u  raw_u;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  assign raw_u = raw_i;

  // halfword lane comes from the upper offset bit
  assign byte_sel = raw_u.b[offset_i];
  assign half_sel = raw_u.h[offset_i[1]];

  always_comb
  begin
    case (op_i)
      LB:      data_o = {{24{byte_sel[7]}}, byte_sel};
      LBU:     data_o = {24'b0, byte_sel};
      LH:      data_o = {{16{half_sel[15]}}, half_sel};
      LHU:     data_o = {16'b0, half_sel};
      default: data_o = raw_i;
    endcase
  end

endmodule

// File: rtl/lsu_top.sv
`timescale 1ns/100ps

module lsu_top
  import lsu_pkg::*;
(
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              req_valid_i,
  input  mem_op_e           req_op_i,
  input  logic [ADDR_W-1:0] req_addr_i,
  input  data_word_t        req_wdata_i,
  output logic              req_ready_o,
  output logic              load_valid_o,
  output data_word_t        load_data_o,
  output logic              store_done_o,
  output logic              ar_valid_o,
  output logic [ADDR_W-1:0] ar_addr_o,
  input  logic              r_valid_i,
  input  data_word_t        r_data_i,
  output logic              aw_valid_o,
  output logic [ADDR_W-1:0] aw_addr_o,
  output data_word_t        w_data_o,
  output logic [STRB_W-1:0] w_strb_o,
  input  logic              w_ready_i
);

  data_word_t raw_data;
  mem_op_e    op;
  logic [1:0] offset;

  l1d_if l1d_bus ();

  lsu_ctrl u_ctrl (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_ready_o  (req_ready_o),
    .ar_valid_o   (ar_valid_o),
    .ar_addr_o    (ar_addr_o),
    .r_valid_i    (r_valid_i),
    .r_data_i     (r_data_i),
    .aw_valid_o   (aw_valid_o),
    .aw_addr_o    (aw_addr_o),
    .w_data_o     (w_data_o),
    .w_strb_o     (w_strb_o),
    .w_ready_i    (w_ready_i),
    .raw_valid_o  (load_valid_o),
    .raw_data_o   (raw_data),
    .op_o         (op),
    .offset_o     (offset),
    .store_done_o (store_done_o),
    .cache        (l1d_bus.ctrl)
  );

  l1d_cache u_cache (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .l1d      (l1d_bus.cache)
  );

  load_align u_align (
    .raw_i    (raw_data),
    .op_i     (op),
    .offset_i (offset),
    .data_o   (load_data_o)
  );

endmodule

// File: tb/clk_gen.sv
`timescale 1ns/100ps

module clk_gen
(
  output logic clk,
  output logic arst_n_o
);

  // 8 ns period
  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // reset held low over two rising edges
  initial
  begin
    arst_n_o = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n_o = 1'b1;
  end

endmodule

// File: tb/tb_top.sv
`timescale 1ns/100ps

module tb_top
  import lsu_pkg::*;
  import cache_pkg::*;
();

  typedef struct packed
  {
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;
    data_word_t        wdata;
    data_word_t        exp_data;
    logic              exp_hit;
  } stim_t;

  logic              clk;
  logic              arst_n;
  logic              req_valid;
  mem_op_e           req_op;
  logic [ADDR_W-1:0] req_addr;
  data_word_t        req_wdata;
  logic              req_ready;
  logic              load_valid;
  data_word_t        load_data;
  logic              store_done;
  logic              ar_valid;
  logic [ADDR_W-1:0] ar_addr;
  logic              r_valid;
  data_word_t        r_data;
  logic              aw_valid;
  logic [ADDR_W-1:0] aw_addr;
  data_word_t        w_data;
  logic [STRB_W-1:0] w_strb;
  logic              w_ready;

  stim_t                     stim [$];
  data_word_t                mem [logic [ADDR_W-1:0]];
  data_word_t                ref_mem [logic [ADDR_W-1:0]];
  logic [L1D_LINES-1:0]      ref_valid = '0;
  l1d_tag_t                  ref_tag [L1D_LINES] = '{default: '0};
  logic [31:0]               lfsr_state = 32'd73396;
  int                        ar_count = 0;

  clk_gen u_clk_gen (
    .clk      (clk),
    .arst_n_o (arst_n)
  );

  lsu_top dut (
    .clk          (clk),
    .arst_n_i     (arst_n),
    .req_valid_i  (req_valid),
    .req_op_i     (req_op),
    .req_addr_i   (req_addr),
    .req_wdata_i  (req_wdata),
    .req_ready_o  (req_ready),
    .load_valid_o (load_valid),
    .load_data_o  (load_data),
    .store_done_o (store_done),
    .ar_valid_o   (ar_valid),
    .ar_addr_o    (ar_addr),
    .r_valid_i    (r_valid),
    .r_data_i     (r_data),
    .aw_valid_o   (aw_valid),
    .aw_addr_o    (aw_addr),
    .w_data_o     (w_data),
    .w_strb_o     (w_strb),
    .w_ready_i    (w_ready)
  );

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  task automatic draw_delay(output int d);
    d = 0;
    repeat (2)
    begin
      d = (d << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // unwritten words depend on every address bit
  function automatic data_word_t fill_word(input logic [ADDR_W-1:0] a);
    return {a[7:0], a[31:24], a[15:8], a[23:16]} ^ 32'hc3a5_5a3c;
  endfunction

  function automatic data_word_t ref_word(input logic [ADDR_W-1:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  function automatic logic is_store(input mem_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

  function automatic logic in_cache_range(input logic [ADDR_W-1:0] a);
    return ((a >= CACHE_RANGE_0_LO) && (a < CACHE_RANGE_0_HI)) ||
           ((a >= CACHE_RANGE_1_LO) && (a < CACHE_RANGE_1_HI));
  endfunction

  function automatic data_word_t merge_store(input mem_op_e op, input logic [1:0] off,
                                             input data_word_t old, input data_word_t wd);
    data_word_t result;
    result = old;
    case (op)
      SB:
        result[8 * off +: 8] = wd[7:0];
      SH:
        result[8 * off +: 16] = wd[15:0];
      default:
        result = wd;
    endcase
    return result;
  endfunction

  function automatic data_word_t expect_load(input mem_op_e op, input logic [1:0] off,
                                             input data_word_t w);
    logic [7:0]  bsel;
    logic [15:0] hsel;
    bsel = w[8 * off +: 8];
    hsel = w[16 * off[1] +: 16];
    case (op)
      LB:
        return {{24{bsel[7]}}, bsel};
      LBU:
        return {24'h0, bsel};
      LH:
        return {{16{hsel[15]}}, hsel};
      LHU:
        return {16'h0, hsel};
      default:
        return w;
    endcase
  endfunction

  task automatic add_store(input mem_op_e op, input logic [ADDR_W-1:0] a,
                           input data_word_t wd);
    logic [ADDR_W-1:0] waddr;
    stim_t             s;
    waddr = {a[31:2], 2'b00};
    ref_mem[waddr] = merge_store(op, a[1:0], ref_word(waddr), wd);
    // a store drops the line when the tag matches
    if (ref_tag[a[5:2]] == a[31:6])
      ref_valid[a[5:2]] = 1'b0;
    s = '{op: op, addr: a, wdata: wd, exp_data: '0, exp_hit: 1'b0};
    stim.push_back(s);
  endtask

  task automatic add_load(input mem_op_e op, input logic [ADDR_W-1:0] a);
    logic [ADDR_W-1:0] waddr;
    logic              hit;
    stim_t             s;
    waddr = {a[31:2], 2'b00};
    hit = ref_valid[a[5:2]] && (ref_tag[a[5:2]] == a[31:6]);
    if (!hit && in_cache_range(a))
    begin
      ref_valid[a[5:2]] = 1'b1;
      ref_tag[a[5:2]]   = a[31:6];
    end
    s = '{op: op, addr: a, wdata: '0,
          exp_data: expect_load(op, a[1:0], ref_word(waddr)), exp_hit: hit};
    stim.push_back(s);
  endtask

  task automatic build_table();
    // merged stores then byte and half extension
    add_store(SW, 32'h8000_0100, 32'h1122_3344);
    add_load(LW, 32'h8000_0100);
    add_store(SB, 32'h8000_0101, 32'h0000_00ab);
    add_load(LW, 32'h8000_0100);
    add_store(SB, 32'h8000_0100, 32'h7777_77c1);
    add_store(SB, 32'h8000_0102, 32'h0000_0052);
    add_store(SB, 32'h8000_0103, 32'hffff_ffe3);
    add_load(LW, 32'h8000_0100);
    add_store(SH, 32'h8000_0100, 32'h5555_9a0f);
    add_store(SH, 32'h8000_0102, 32'h0000_3cd4);
    add_load(LW, 32'h8000_0100);
    add_load(LW, 32'h8000_0100);
    add_store(SW, 32'h8000_0108, 32'h80f1_7f02);
    for (int off = 0; off < 4; off++)
    begin
      add_load(LB, 32'h8000_0108 + off);
      add_load(LBU, 32'h8000_0108 + off);
    end
    for (int off = 0; off < 4; off += 2)
    begin
      add_load(LH, 32'h8000_0108 + off);
      add_load(LHU, 32'h8000_0108 + off);
    end
    // non-cacheable region always goes to the bus
    add_load(LW, 32'h1000_0000);
    add_load(LW, 32'h1000_0000);
    add_load(LB, 32'h1000_0003);
    // invalidate on store in region 1
    add_load(LW, 32'ha000_0010);
    add_load(LW, 32'ha000_0010);
    add_store(SW, 32'ha000_0010, 32'hdead_0b0e);
    add_load(LW, 32'ha000_0010);
    add_load(LW, 32'ha000_0010);
    add_store(SH, 32'ha000_0012, 32'h0000_8001);
    add_load(LH, 32'ha000_0012);
    // same index with different tags
    add_load(LW, 32'h8000_0234);
    add_load(LW, 32'ha000_1234);
    add_load(LW, 32'h8000_0234);
    add_load(LW, 32'h8000_0234);
    add_load(LHU, 32'ha000_1236);
  endtask

  task automatic report_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_word_t exp, input data_word_t act);
    if (act !== exp)
    begin
      $display("ERR %0t %s exp=%08h act=%08h", $time, name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_hit(input string name, input int exp, input int act);
    if (act != exp)
    begin
      $display("ERR %0t %s exp=%0d act=%0d", $time, name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("ERR %0t %s exp=%b act=%b", $time, name, exp, act);
      report_failure();
    end
  endtask

  task automatic run_entry(input stim_t s);
    int reads_before;
    int exp_reads;
    reads_before = ar_count;
    while (!req_ready)
      @(negedge clk);
    req_valid = 1'b1;
    req_op    = s.op;
    req_addr  = s.addr;
    req_wdata = s.wdata;
    @(negedge clk);
    req_valid = 1'b0;
    while (!(load_valid || store_done))
      @(negedge clk);
    // the pulse must match the kind of operation
    check_ready("load_valid_o", !is_store(s.op), load_valid);
    check_ready("store_done_o", is_store(s.op), store_done);
    check_ready("req_ready_o", 1'b1, req_ready);
    if (!is_store(s.op))
      check_data("load_data_o", s.exp_data, load_data);
    exp_reads = (!is_store(s.op) && !s.exp_hit) ? 1 : 0;
    check_hit("ar_valid_o count", exp_reads, ar_count - reads_before);
  endtask

  // bus read side answers after 0 to 3 cycles
  initial
  begin
    int delay;
    r_valid = 1'b0;
    r_data  = '0;
    forever
    begin
      @(negedge clk);
      r_valid = 1'b0;
      if (ar_valid)
      begin
        ar_count++;
        draw_delay(delay);
        repeat (delay) @(negedge clk);
        r_data  = mem.exists(ar_addr) ? mem[ar_addr] : fill_word(ar_addr);
        r_valid = 1'b1;
      end
    end
  end

  // bus write side applies the strobe per byte
  initial
  begin
    int         delay;
    data_word_t word;
    w_ready = 1'b0;
    forever
    begin
      @(negedge clk);
      w_ready = 1'b0;
      if (aw_valid)
      begin
        draw_delay(delay);
        repeat (delay) @(negedge clk);
        word = mem.exists(aw_addr) ? mem[aw_addr] : fill_word(aw_addr);
        for (int i = 0; i < STRB_W; i++)
        begin
          if (w_strb[i])
            word[8 * i +: 8] = w_data[8 * i +: 8];
        end
        mem[aw_addr] = word;
        w_ready = 1'b1;
      end
    end
  end

  initial
  begin
    #1;
    repeat (stim.size() * 20 + 10) @(posedge clk);
    $display("timeout: no result from the DUT within %0d table entries", stim.size());
    report_failure();
  end

  initial
  begin
    req_valid = 1'b0;
    req_op    = LW;
    req_addr  = '0;
    req_wdata = '0;
    build_table();
    @(posedge arst_n);
    @(negedge clk);
    check_ready("req_ready_o", 1'b1, req_ready);
    check_ready("ar_valid_o", 1'b0, ar_valid);
    check_ready("aw_valid_o", 1'b0, aw_valid);
    check_ready("load_valid_o", 1'b0, load_valid);
    check_ready("store_done_o", 1'b0, store_done);
    foreach (stim[i])
      run_entry(stim[i]);
    @(negedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: list.f
rtl/lsu_pkg.sv
rtl/cache_pkg.sv
rtl/l1d_if.sv
rtl/lsu_ctrl.sv
rtl/l1d_cache.sv
rtl/load_align.sv
rtl/lsu_top.sv
tb/clk_gen.sv
tb/tb_top.sv

// File: Makefile
# Verilator simulation of the load/store unit

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

# the log decides pass or fail, so the run status is not used
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
